/* hdl/riscv_isa_pkg.sv */
package riscv_isa_pkg;

  //////////////////////////////////////////////////
  // Architectural widths
  //////////////////////////////////////////////////

  parameter int XLEN       = 32;  // Register and data width
  parameter int REG_ADDR_W = 5;   // x0 .. x31

  // Major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111
  } opcode_e;

  // ALU operations
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS_B  // LUI, immediate straight through
  } alu_op_e;

  // funct3 fields
  parameter logic [2:0] FUNCT3_ADD_SUB = 3'b000;
  parameter logic [2:0] FUNCT3_XOR     = 3'b100;
  parameter logic [2:0] FUNCT3_OR      = 3'b110;
  parameter logic [2:0] FUNCT3_AND     = 3'b111;
  parameter logic [2:0] FUNCT3_WORD    = 3'b010;  // LW and SW
  parameter logic [2:0] FUNCT3_BEQ     = 3'b000;
  parameter logic [2:0] FUNCT3_BNE     = 3'b001;

  parameter logic [6:0] FUNCT7_SUB     = 7'b0100000;  // Only instr[30] differs from ADD

endpackage

/* hdl/riscv_bus_pkg.sv */
package riscv_bus_pkg;

  parameter int ADDR_W = 32;  // Byte address
  parameter int DATA_W = 32;  // Word on both ports

  // Instruction fetch sequencer
  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_REQ,   // req high, waiting for gnt
    FETCH_WAIT   // Granted, waiting for rvalid
  } fetch_state_e;

  // Load/store sequencer, same shape as fetch
  typedef enum logic [1:0] {
    LSU_IDLE,
    LSU_REQ,
    LSU_WAIT
  } lsu_state_e;

endpackage

/* hdl/riscv_alu.sv */
`timescale 1ns/1ps

module riscv_alu (
  input  riscv_isa_pkg::alu_op_e         operator_i,
  input  logic [riscv_isa_pkg::XLEN-1:0] operand_a_i,
  input  logic [riscv_isa_pkg::XLEN-1:0] operand_b_i,
  output logic [riscv_isa_pkg::XLEN-1:0] result_o,
  output logic                           equal_o      // Branch compare
);

  always_comb begin
    case (operator_i)
      riscv_isa_pkg::ALU_ADD:    result_o = operand_a_i + operand_b_i;
      riscv_isa_pkg::ALU_SUB:    result_o = operand_a_i - operand_b_i;
      riscv_isa_pkg::ALU_AND:    result_o = operand_a_i & operand_b_i;
      riscv_isa_pkg::ALU_OR:     result_o = operand_a_i | operand_b_i;
      riscv_isa_pkg::ALU_XOR:    result_o = operand_a_i ^ operand_b_i;
      riscv_isa_pkg::ALU_PASS_B: result_o = operand_b_i;  // LUI
      default:                   result_o = '0;
    endcase
  end

  assign equal_o = (operand_a_i == operand_b_i);

endmodule

/* hdl/riscv_register_file.sv */
`timescale 1ns/1ps

module riscv_register_file (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  logic [riscv_isa_pkg::REG_ADDR_W-1:0] raddr_a_i,
  input  logic [riscv_isa_pkg::REG_ADDR_W-1:0] raddr_b_i,
  output logic [riscv_isa_pkg::XLEN-1:0]       rdata_a_o,
  output logic [riscv_isa_pkg::XLEN-1:0]       rdata_b_o,
  input  logic                                 we_i,
  input  logic [riscv_isa_pkg::REG_ADDR_W-1:0] waddr_i,
  input  logic [riscv_isa_pkg::XLEN-1:0]       wdata_i
);

  // x0 .. x31, x0 cleared on reset and never written
  logic [riscv_isa_pkg::XLEN-1:0] regs_q [0:2**riscv_isa_pkg::REG_ADDR_W-1];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < 2**riscv_isa_pkg::REG_ADDR_W; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin  // Writes to x0 dropped
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = regs_q[raddr_a_i];
  assign rdata_b_o = regs_q[raddr_b_i];

  // x0 storage stays zero after every write
  a_x0_zero: assert property (@(posedge clk_i) disable iff (reset_i)
    regs_q[0] == '0)
    else $error("x0 held a nonzero value");

endmodule

/* hdl/riscv_if_stage.sv */
`timescale 1ns/1ps

module riscv_if_stage (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             fetch_start_i,   // One-cycle pulse from ID
  input  logic [riscv_bus_pkg::ADDR_W-1:0] next_pc_i,
  output logic                             fetch_valid_o,
  output logic [riscv_bus_pkg::DATA_W-1:0] fetch_rdata_o,
  output logic [riscv_bus_pkg::ADDR_W-1:0] pc_id_o,
  output logic                             instr_req_o,
  output logic [riscv_bus_pkg::ADDR_W-1:0] instr_addr_o,
  input  logic                             instr_gnt_i,
  input  logic                             instr_rvalid_i,
  input  logic [riscv_bus_pkg::DATA_W-1:0] instr_rdata_i
);

  riscv_bus_pkg::fetch_state_e      state_q;
  logic [riscv_bus_pkg::ADDR_W-1:0] pc_q;  // Stays put until the next fetch_start

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= riscv_bus_pkg::FETCH_IDLE;
    end else begin
      case (state_q)
        riscv_bus_pkg::FETCH_IDLE: if (fetch_start_i) state_q <= riscv_bus_pkg::FETCH_REQ;
        riscv_bus_pkg::FETCH_REQ:  if (instr_gnt_i)   state_q <= riscv_bus_pkg::FETCH_WAIT;
        riscv_bus_pkg::FETCH_WAIT: if (instr_rvalid_i) state_q <= riscv_bus_pkg::FETCH_IDLE;
        default:                   state_q <= riscv_bus_pkg::FETCH_IDLE;
      endcase
    end
  end

  // PC, payload only
  always_ff @(posedge clk_i) begin
    if (fetch_start_i) begin
      pc_q <= next_pc_i;
    end
  end

  assign instr_req_o   = (state_q == riscv_bus_pkg::FETCH_REQ);
  assign instr_addr_o  = pc_q;
  assign pc_id_o       = pc_q;      // Same PC serves decode
  assign fetch_valid_o = (state_q == riscv_bus_pkg::FETCH_WAIT) && instr_rvalid_i;
  assign fetch_rdata_o = instr_rdata_i;

  // Request and address held until granted
  a_instr_req_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
    else $error("instruction request dropped or moved before grant");

endmodule

/* hdl/riscv_id_stage.sv */
`timescale 1ns/1ps

module riscv_id_stage (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic [riscv_isa_pkg::XLEN-1:0] boot_addr_i,
  input  logic                           fetch_enable_i,
  output logic                           fetch_start_o,
  output logic [riscv_isa_pkg::XLEN-1:0] next_pc_o,
  input  logic                           fetch_valid_i,
  input  logic [riscv_isa_pkg::XLEN-1:0] fetch_rdata_i,
  input  logic [riscv_isa_pkg::XLEN-1:0] pc_id_i,
  output logic                           lsu_start_o,
  output logic                           lsu_we_o,
  output logic [riscv_isa_pkg::XLEN-1:0] lsu_addr_o,
  output logic [riscv_isa_pkg::XLEN-1:0] lsu_wdata_o,
  input  logic                           lsu_done_i,
  input  logic [riscv_isa_pkg::XLEN-1:0] lsu_rdata_i,
  output logic                           core_busy_o
);

  typedef enum logic [1:0] {ID_IDLE, ID_FETCH, ID_EXEC, ID_MEM} id_state_e;

  id_state_e                             state_q;
  logic [riscv_isa_pkg::XLEN-1:0]        instr_q;
  logic [riscv_isa_pkg::XLEN-1:0]        resume_pc_q;  // Next PC while parked in idle
  riscv_isa_pkg::opcode_e                opcode;
  logic [2:0]                            funct3;
  logic [riscv_isa_pkg::REG_ADDR_W-1:0]  rd, rs1, rs2;
  logic [riscv_isa_pkg::XLEN-1:0]        imm_i, imm_s, imm_b, imm_j, imm_u;
  logic [riscv_isa_pkg::XLEN-1:0]        rs1_data, rs2_data;
  logic [riscv_isa_pkg::XLEN-1:0]        pc_plus4, pc_target;
  riscv_isa_pkg::alu_op_e                alu_operator;
  logic [riscv_isa_pkg::XLEN-1:0]        alu_operand_b, alu_result;
  logic                                  alu_equal;
  logic                                  alu_wb, jump, mem_access, mem_we, retire;
  logic                                  rf_we;
  logic [riscv_isa_pkg::XLEN-1:0]        rf_wdata;

  //////////////////////////////////////////////////
  // Field and immediate extraction
  //////////////////////////////////////////////////
  assign opcode = riscv_isa_pkg::opcode_e'(instr_q[6:0]);
  assign funct3 = instr_q[14:12];
  assign rd     = instr_q[11:7];
  assign rs1    = instr_q[19:15];
  assign rs2    = instr_q[24:20];

  assign imm_i = {{20{instr_q[31]}}, instr_q[31:20]};
  assign imm_s = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
  assign imm_b = {{19{instr_q[31]}}, instr_q[31], instr_q[7], instr_q[30:25], instr_q[11:8], 1'b0};
  assign imm_j = {{11{instr_q[31]}}, instr_q[31], instr_q[19:12], instr_q[20],
                  instr_q[30:21], 1'b0};
  assign imm_u = {instr_q[31:12], 12'b0};

  // Decoder, anything unlisted is a no-op
  always_comb begin
    alu_operator  = riscv_isa_pkg::ALU_ADD;  // Also forms load/store address
    alu_operand_b = imm_i;
    alu_wb        = 1'b0;
    jump          = 1'b0;
    mem_access    = 1'b0;
    mem_we        = 1'b0;
    case (opcode)
      riscv_isa_pkg::OP, riscv_isa_pkg::OP_IMM: begin
        alu_operand_b = (opcode == riscv_isa_pkg::OP) ? rs2_data : imm_i;
        alu_wb        = 1'b1;
        case (funct3)
          riscv_isa_pkg::FUNCT3_ADD_SUB: begin
            if (opcode == riscv_isa_pkg::OP && instr_q[31:25] == riscv_isa_pkg::FUNCT7_SUB) begin
              alu_operator = riscv_isa_pkg::ALU_SUB;
            end
          end
          riscv_isa_pkg::FUNCT3_XOR: alu_operator = riscv_isa_pkg::ALU_XOR;
          riscv_isa_pkg::FUNCT3_OR:  alu_operator = riscv_isa_pkg::ALU_OR;
          riscv_isa_pkg::FUNCT3_AND: alu_operator = riscv_isa_pkg::ALU_AND;
          default:                   alu_wb       = 1'b0;  // Shifts, compares
        endcase
      end
      riscv_isa_pkg::LUI: begin
        alu_operator  = riscv_isa_pkg::ALU_PASS_B;
        alu_operand_b = imm_u;
        alu_wb        = 1'b1;
      end
      riscv_isa_pkg::LOAD:  mem_access = (funct3 == riscv_isa_pkg::FUNCT3_WORD);
      riscv_isa_pkg::STORE: begin
        alu_operand_b = imm_s;
        mem_access    = (funct3 == riscv_isa_pkg::FUNCT3_WORD);
        mem_we        = 1'b1;
      end
      riscv_isa_pkg::BRANCH: begin
        alu_operand_b = rs2_data;  // Equality flag only
        jump = (funct3 == riscv_isa_pkg::FUNCT3_BEQ &&  alu_equal) ||
               (funct3 == riscv_isa_pkg::FUNCT3_BNE && !alu_equal);
      end
      riscv_isa_pkg::JAL: jump = 1'b1;
      default: ;
    endcase
  end

  //////////////////////////////////////////////////
  // Next PC and retire control
  //////////////////////////////////////////////////
  assign pc_plus4  = pc_id_i + 32'd4;
  assign pc_target = pc_id_i + ((opcode == riscv_isa_pkg::JAL) ? imm_j : imm_b);
  assign next_pc_o = (state_q == ID_IDLE) ? resume_pc_q : (jump ? pc_target : pc_plus4);

  assign retire        = (state_q == ID_EXEC && !mem_access) || (state_q == ID_MEM && lsu_done_i);
  assign fetch_start_o = fetch_enable_i && (retire || state_q == ID_IDLE);
  assign lsu_start_o   = (state_q == ID_EXEC) && mem_access;
  assign lsu_we_o      = mem_we;
  assign lsu_addr_o    = alu_result;  // rs1 + imm
  assign lsu_wdata_o   = rs2_data;
  assign core_busy_o   = (state_q != ID_IDLE);

  // Write-back, loads land on lsu_done
  assign rf_we    = (state_q == ID_EXEC && (alu_wb || opcode == riscv_isa_pkg::JAL)) ||
                    (state_q == ID_MEM && lsu_done_i && !mem_we);
  assign rf_wdata = (state_q == ID_MEM) ? lsu_rdata_i :
                    (opcode == riscv_isa_pkg::JAL) ? pc_plus4 : alu_result;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q     <= ID_IDLE;
      resume_pc_q <= boot_addr_i;  // First fetch goes to boot address
    end else begin
      if (retire) resume_pc_q <= next_pc_o;
      case (state_q)
        ID_IDLE:  if (fetch_enable_i) state_q <= ID_FETCH;
        ID_FETCH: if (fetch_valid_i)  state_q <= ID_EXEC;
        ID_EXEC:  state_q <= mem_access ? ID_MEM : (fetch_enable_i ? ID_FETCH : ID_IDLE);
        ID_MEM:   if (lsu_done_i) state_q <= fetch_enable_i ? ID_FETCH : ID_IDLE;
        default:  state_q <= ID_IDLE;
      endcase
    end
  end

  // Instruction register
  always_ff @(posedge clk_i) begin
    if (fetch_valid_i) begin
      instr_q <= fetch_rdata_i;
    end
  end

  riscv_register_file registers_i (
    .clk_i     ( clk_i    ),
    .reset_i   ( reset_i  ),
    .raddr_a_i ( rs1      ),
    .raddr_b_i ( rs2      ),
    .rdata_a_o ( rs1_data ),
    .rdata_b_o ( rs2_data ),
    .we_i      ( rf_we    ),
    .waddr_i   ( rd       ),
    .wdata_i   ( rf_wdata )
  );

  riscv_alu alu_i (
    .operator_i  ( alu_operator  ),
    .operand_a_i ( rs1_data      ),
    .operand_b_i ( alu_operand_b ),
    .result_o    ( alu_result    ),
    .equal_o     ( alu_equal     )
  );

endmodule

/* hdl/riscv_load_store_unit.sv */
`timescale 1ns/1ps

module riscv_load_store_unit (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             lsu_start_i,  // Pulse from ID
  input  logic                             lsu_we_i,
  input  logic [riscv_bus_pkg::ADDR_W-1:0] lsu_addr_i,
  input  logic [riscv_bus_pkg::DATA_W-1:0] lsu_wdata_i,
  output logic                             lsu_done_o,
  output logic [riscv_bus_pkg::DATA_W-1:0] lsu_rdata_o,
  output logic                             data_req_o,
  output logic                             data_we_o,
  output logic [riscv_bus_pkg::ADDR_W-1:0] data_addr_o,
  output logic [riscv_bus_pkg::DATA_W-1:0] data_wdata_o,
  input  logic                             data_gnt_i,
  input  logic                             data_rvalid_i,
  input  logic [riscv_bus_pkg::DATA_W-1:0] data_rdata_i
);

  riscv_bus_pkg::lsu_state_e        state_q;
  logic                             we_q;
  logic [riscv_bus_pkg::ADDR_W-1:0] addr_q;
  logic [riscv_bus_pkg::DATA_W-1:0] wdata_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= riscv_bus_pkg::LSU_IDLE;
    end else begin
      case (state_q)
        riscv_bus_pkg::LSU_IDLE: if (lsu_start_i)   state_q <= riscv_bus_pkg::LSU_REQ;
        riscv_bus_pkg::LSU_REQ:  if (data_gnt_i)    state_q <= riscv_bus_pkg::LSU_WAIT;
        riscv_bus_pkg::LSU_WAIT: if (data_rvalid_i) state_q <= riscv_bus_pkg::LSU_IDLE;
        default:                 state_q <= riscv_bus_pkg::LSU_IDLE;
      endcase
    end
  end

  // Request payload, captured once per access
  always_ff @(posedge clk_i) begin
    if (lsu_start_i) begin
      we_q    <= lsu_we_i;
      addr_q  <= lsu_addr_i;
      wdata_q <= lsu_wdata_i;
    end
  end

  assign data_req_o   = (state_q == riscv_bus_pkg::LSU_REQ);
  assign data_we_o    = we_q;
  assign data_addr_o  = addr_q;
  assign data_wdata_o = wdata_q;

  // Stores complete on rvalid too
  assign lsu_done_o  = (state_q == riscv_bus_pkg::LSU_WAIT) && data_rvalid_i;
  assign lsu_rdata_o = data_rdata_i;

  a_data_req_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    data_req_o && !data_gnt_i |=> data_req_o && $stable(data_addr_o) &&
                                  $stable(data_wdata_o) && $stable(data_we_o))
    else $error("data request dropped or changed before grant");

endmodule

/* hdl/riscv_core.sv */
`timescale 1ns/1ps

module riscv_core (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic [31:0] boot_addr_i,
  input  logic        fetch_enable_i,
  output logic        core_busy_o,

  // Instruction memory port
  output logic        instr_req_o,
  output logic [31:0] instr_addr_o,
  input  logic        instr_gnt_i,
  input  logic        instr_rvalid_i,
  input  logic [31:0] instr_rdata_i,

  // Data memory port
  output logic        data_req_o,
  output logic        data_we_o,
  output logic [31:0] data_addr_o,
  output logic [31:0] data_wdata_o,
  input  logic        data_gnt_i,
  input  logic        data_rvalid_i,
  input  logic [31:0] data_rdata_i
);

  // IF <-> ID
  logic                              fetch_valid;
  logic [riscv_isa_pkg::XLEN-1:0]    fetch_rdata;
  logic [riscv_bus_pkg::ADDR_W-1:0]  pc_id;
  logic                              fetch_start;
  logic [riscv_bus_pkg::ADDR_W-1:0]  next_pc;

  // ID <-> LSU
  logic                              lsu_start;
  logic                              lsu_we;
  logic [riscv_bus_pkg::ADDR_W-1:0]  lsu_addr;
  logic [riscv_isa_pkg::XLEN-1:0]    lsu_wdata;
  logic                              lsu_done;
  logic [riscv_isa_pkg::XLEN-1:0]    lsu_rdata;

  //////////////////////////////////////////////////
  // Instruction fetch
  //////////////////////////////////////////////////
  riscv_if_stage if_stage_i (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .fetch_start_i  ( fetch_start    ),
    .next_pc_i      ( next_pc        ),
    .fetch_valid_o  ( fetch_valid    ),
    .fetch_rdata_o  ( fetch_rdata    ),
    .pc_id_o        ( pc_id          ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  )
  );

  //////////////////////////////////////////////////
  // Decode, execute and retire
  //////////////////////////////////////////////////
  riscv_id_stage id_stage_i (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .boot_addr_i    ( boot_addr_i    ),
    .fetch_enable_i ( fetch_enable_i ),
    .fetch_start_o  ( fetch_start    ),
    .next_pc_o      ( next_pc        ),
    .fetch_valid_i  ( fetch_valid    ),
    .fetch_rdata_i  ( fetch_rdata    ),
    .pc_id_i        ( pc_id          ),
    .lsu_start_o    ( lsu_start      ),
    .lsu_we_o       ( lsu_we         ),
    .lsu_addr_o     ( lsu_addr       ),
    .lsu_wdata_o    ( lsu_wdata      ),
    .lsu_done_i     ( lsu_done       ),
    .lsu_rdata_i    ( lsu_rdata      ),
    .core_busy_o    ( core_busy_o    )  // Straight from ID control
  );

  //////////////////////////////////////////////////
  // Load/store unit
  //////////////////////////////////////////////////
  riscv_load_store_unit load_store_unit_i (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .lsu_start_i    ( lsu_start      ),
    .lsu_we_i       ( lsu_we         ),
    .lsu_addr_i     ( lsu_addr       ),
    .lsu_wdata_i    ( lsu_wdata      ),
    .lsu_done_o     ( lsu_done       ),
    .lsu_rdata_o    ( lsu_rdata      ),
    .data_req_o     ( data_req_o     ),
    .data_we_o      ( data_we_o      ),
    .data_addr_o    ( data_addr_o    ),
    .data_wdata_o   ( data_wdata_o   ),
    .data_gnt_i     ( data_gnt_i     ),
    .data_rvalid_i  ( data_rvalid_i  ),
    .data_rdata_i   ( data_rdata_i   )
  );

endmodule

/* sim/tb_riscv_core.sv */
`timescale 1ns/1ps

module tb_riscv_core;

  logic        clk_i = 1'b0;
  logic        reset_i;
  logic [31:0] boot_addr_i;
  logic        fetch_enable_i;
  logic        core_busy_o;
  logic        instr_req_o, instr_gnt_i, instr_rvalid_i;
  logic [31:0] instr_addr_o, instr_rdata_i;
  logic        data_req_o, data_we_o, data_gnt_i, data_rvalid_i;
  logic [31:0] data_addr_o, data_wdata_o, data_rdata_i;

  logic [31:0] imem [0:255];              // Word index is addr[9:2]
  logic [31:0] dmem [0:255];
  logic [31:0] exp_addr_q [$];            // Expected stores, program order
  logic [31:0] exp_data_q [$];
  logic [31:0] halt_pc;                   // Last program word, JAL to itself
  int          prog_words  = 0;
  int          cycle_count = 0;
  int          cycle_limit = 1000;
  logic [31:0] rng_state   = 32'd29091;

  // Memory model state
  logic        instr_granted = 1'b0, data_granted = 1'b0;
  logic [1:0]  instr_gnt_wait = 2'd0, instr_rv_wait = 2'd0;
  logic [1:0]  data_gnt_wait = 2'd0, data_rv_wait = 2'd0;
  logic [7:0]  instr_word, data_word;
  logic        data_is_store;
  logic        instr_hold = 1'b0, data_hold = 1'b0;  // Request left ungranted last cycle
  logic [31:0] instr_hold_addr, data_hold_addr, data_hold_wdata;

  riscv_core dut_i (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .boot_addr_i    ( boot_addr_i    ),
    .fetch_enable_i ( fetch_enable_i ),
    .core_busy_o    ( core_busy_o    ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .data_req_o     ( data_req_o     ),
    .data_we_o      ( data_we_o      ),
    .data_addr_o    ( data_addr_o    ),
    .data_wdata_o   ( data_wdata_o   ),
    .data_gnt_i     ( data_gnt_i     ),
    .data_rvalid_i  ( data_rvalid_i  ),
    .data_rdata_i   ( data_rdata_i   )
  );

  always #10 clk_i = ~clk_i;  // 20 ns period

  //////////////////////////////////////////////////
  // Failure reporting and random waits
  //////////////////////////////////////////////////
  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
      else report_failure($sformatf("** Error at %0t ns: %s expected %08h, actual %08h",
                                    $time, name, expected, actual));
  endtask

  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic draw_wait(output logic [1:0] cycles);
    rng_state = lcg_step(rng_state);
    cycles    = rng_state[17:16];  // 0 to 3
  endtask

  //////////////////////////////////////////////////
  // Pattern file
  //////////////////////////////////////////////////
  task automatic load_patterns();
    int                 fd;
    int                 code;
    bit                 reading;
    logic [7:0]         tag;
    logic [31:0]        addr_val, data_val;
    logic [8*128-1:0]   line_buf;
    for (int i = 0; i < 256; i++) begin
      imem[i] = 32'h0000_0013;                      // Unloaded words are NOPs
      dmem[i] = {16'hDA7A, 6'b0, i[7:0], 2'b00};    // Own byte address in low half
    end
    fd = $fopen("sim/core_patterns.txt", "r");
    assert (fd != 0) else report_failure("cannot open sim/core_patterns.txt");
    reading = 1'b1;
    while (reading) begin
      code = $fscanf(fd, "%s", tag);
      if (code != 1) begin
        reading = 1'b0;                             // End of file
      end else if (tag == "#") begin
        code = $fgets(line_buf, fd);                // Rest of a comment line
      end else begin
        code = $fscanf(fd, "%h %h", addr_val, data_val);
        assert (code == 2) else report_failure("malformed record in pattern file");
        case (tag)
          "P": begin
            imem[addr_val[9:2]] = data_val;
            halt_pc             = addr_val;
            prog_words++;
          end
          "D": dmem[addr_val[9:2]] = data_val;
          "S": begin
            exp_addr_q.push_back(addr_val);
            exp_data_q.push_back(data_val);
          end
          default: report_failure("unknown record tag in pattern file");
        endcase
      end
    end
    $fclose(fd);
    assert (prog_words > 0 && exp_addr_q.size() > 0)
      else report_failure("pattern file holds no program or no expected stores");
    cycle_limit = 40 * prog_words + 60;  // Plus boot idle and halt windows
  endtask

  //////////////////////////////////////////////////
  // Memory models, 0 to 3 waits before gnt and rvalid
  //////////////////////////////////////////////////
  task automatic serve_instr_port();
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    if (instr_granted) begin
      if (instr_rv_wait == 2'd0) begin
        instr_rvalid_i = 1'b1;
        instr_rdata_i  = imem[instr_word];
        instr_granted  = 1'b0;
      end else begin
        instr_rv_wait = instr_rv_wait - 2'd1;
      end
    end else if (instr_req_o) begin
      if (instr_gnt_wait == 2'd0) begin
        assert (instr_addr_o < 32'd1024) else report_failure("fetch outside instruction memory");
        instr_gnt_i   = 1'b1;
        instr_word    = instr_addr_o[9:2];
        instr_granted = 1'b1;
        draw_wait(instr_rv_wait);
        draw_wait(instr_gnt_wait);
      end else begin
        instr_gnt_wait = instr_gnt_wait - 2'd1;
      end
    end
  endtask

  task automatic serve_data_port();
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    if (data_granted) begin
      if (data_rv_wait == 2'd0) begin
        data_rvalid_i = 1'b1;
        data_rdata_i  = data_is_store ? 32'd0 : dmem[data_word];
        data_granted  = 1'b0;
      end else begin
        data_rv_wait = data_rv_wait - 2'd1;
      end
    end else if (data_req_o) begin
      if (data_gnt_wait == 2'd0) begin
        assert (data_addr_o < 32'd1024) else report_failure("data access outside memory");
        data_gnt_i    = 1'b1;
        data_word     = data_addr_o[9:2];
        data_is_store = data_we_o;
        data_granted  = 1'b1;
        if (data_we_o) begin  // Store checked against next record
          assert (exp_addr_q.size() > 0)
            else report_failure($sformatf("unexpected store of %08h to %08h",
                                          data_wdata_o, data_addr_o));
          check_value("data_addr_o", exp_addr_q[0], data_addr_o);
          check_value("data_wdata_o", exp_data_q[0], data_wdata_o);
          dmem[data_word] = data_wdata_o;
          void'(exp_addr_q.pop_front());
          void'(exp_data_q.pop_front());
        end
        draw_wait(data_rv_wait);
        draw_wait(data_gnt_wait);
      end else begin
        data_gnt_wait = data_gnt_wait - 2'd1;
      end
    end
  endtask

  always @(posedge clk_i) begin
    #1;
    if (instr_hold) begin  // Ungranted request must hold
      assert (instr_req_o) else report_failure("instr_req_o dropped before its grant");
      check_value("instr_addr_o", instr_hold_addr, instr_addr_o);
    end
    if (data_hold) begin
      assert (data_req_o) else report_failure("data_req_o dropped before its grant");
      check_value("data_addr_o", data_hold_addr, data_addr_o);
      check_value("data_wdata_o", data_hold_wdata, data_wdata_o);
    end
    serve_instr_port();
    serve_data_port();
    instr_hold      = instr_req_o && !instr_gnt_i;
    instr_hold_addr = instr_addr_o;
    data_hold       = data_req_o && !data_gnt_i;
    data_hold_addr  = data_addr_o;
    data_hold_wdata = data_wdata_o;
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      report_failure($sformatf("timeout, run did not end within %0d cycles", cycle_limit));
    end
  end

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////
  initial begin
    int idle_wait;
    reset_i        = 1'b1;
    boot_addr_i    = 32'h0000_0100;
    fetch_enable_i = 1'b0;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = 32'd0;
    data_gnt_i     = 1'b0;
    data_rvalid_i  = 1'b0;
    data_rdata_i   = 32'd0;
    load_patterns();
    repeat (2) @(posedge clk_i);
    #1 reset_i = 1'b0;
    assert (!instr_req_o && !data_req_o && !core_busy_o)
      else report_failure("core active right after reset");

    // Boot with fetch disabled, core stays quiet
    repeat (10) begin
      next_cycle();
      assert (!instr_req_o && !core_busy_o)
        else report_failure("core started while fetch_enable_i was low");
    end
    fetch_enable_i = 1'b1;
    while (!instr_req_o) next_cycle();
    check_value("instr_addr_o", boot_addr_i, instr_addr_o);

    // Program runs until it fetches its halt loop
    while (!(instr_req_o && instr_addr_o == halt_pc)) next_cycle();
    assert (exp_addr_q.size() == 0)
      else report_failure($sformatf("halt reached with %0d stores missing", exp_addr_q.size()));

    fetch_enable_i = 1'b0;
    idle_wait      = 0;
    while (core_busy_o && idle_wait < 20) begin
      next_cycle();
      idle_wait++;
    end
    assert (!core_busy_o) else report_failure("core still busy 20 cycles after fetch disable");
    repeat (20) begin
      next_cycle();
      assert (!core_busy_o && !instr_req_o)
        else report_failure("core fetched again after it went idle");
    end

    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* sources.f */
hdl/riscv_isa_pkg.sv
hdl/riscv_bus_pkg.sv
hdl/riscv_alu.sv
hdl/riscv_register_file.sv
hdl/riscv_if_stage.sv
hdl/riscv_id_stage.sv
hdl/riscv_load_store_unit.sv
hdl/riscv_core.sv
sim/tb_riscv_core.sv

/* run.sh */
#!/usr/bin/env bash
# Build the riscv_core testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f sources.f \
  --top-module tb_riscv_core \
  -o tb_riscv_core

./obj_dir/tb_riscv_core

/* sim/core_patterns.txt */
# tag address data, all hex
# P program word, D initial data word, S expected store in program order
P 00000100 20000513
P 00000104 06400093
P 00000108 ff900113
P 0000010c 123451b7
P 00000110 6781e193
P 00000114 00208233
P 00000118 00452023
P 0000011c 402082b3
P 00000120 00552223
P 00000124 0011f333
P 00000128 00652423
P 0000012c 0011e3b3
P 00000130 00752623
P 00000134 0021c433
P 00000138 00852823
P 0000013c 0f01f493
P 00000140 fff1c593
P 00000144 00952a23
P 00000148 00b52c23
P 0000014c 04052603
P 00000150 12360693
P 00000154 00d52e23
P 00000158 00108463
P 0000015c 02252023
P 00000160 00109463
P 00000164 02152023
P 00000168 0080076f
P 0000016c 02252223
P 00000170 02e52223
P 00000174 03700013
P 00000178 02052423
P 0000017c 0000006f
# Word read by the LW at 0x14c
D 00000240 0badf00d
# ALU results
S 00000200 0000005d
S 00000204 0000006b
S 00000208 00000060
S 0000020c 1234567c
S 00000210 edcba981
S 00000214 00000070
S 00000218 edcba987
# Load, then control flow and x0
S 0000021c 0badf130
S 00000220 00000064
S 00000224 0000016c
S 00000228 00000000
